// ==== sources.f ====
hw/traffic_pkg.sv
hw/road_lane.sv
hw/demand_arbiter.sv
hw/phase_controller.sv
hw/traffic_junction.sv
test/tb_traffic_junction.sv

// ==== Makefile ====
# Verilator build and run for the traffic junction testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_traffic_junction
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(PASS_TEXT)" $(LOG); then \
	  echo "run passed"; \
	else \
	  echo "run failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_traffic_junction.sv ====
`timescale 1ns/1ps

module tb_traffic_junction import traffic_pkg::*; ();

  localparam int NUM_ROADS = 4;
  localparam int MIN_GREEN = 4;
  localparam int TIMEOUT   = 60;

  logic                                       clock;
  logic                                       reset;
  logic [NUM_ROADS-1:0][SENSORS_PER_ROAD-1:0] queue_sensors;
  logic [NUM_ROADS-1:0]                       siren;
  logic [NUM_ROADS-1:0]                       violation_cam;
  lamp_t [NUM_ROADS-1:0]                      lamps;
  logic                                       camera;

  traffic_junction #(
    .NUM_ROADS (NUM_ROADS),
    .MIN_GREEN (MIN_GREEN)
  ) UUT (
    .clock         (clock),
    .reset         (reset),
    .queue_sensors (queue_sensors),
    .siren         (siren),
    .violation_cam (violation_cam),
    .lamps         (lamps),
    .camera        (camera)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      stop_with_failure($sformatf("MISMATCH at time %0t: %s (got %0d, expected %0d)",
                                  $time, msg, actual, expected));
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1; // inputs change and outputs are read well clear of the edge.
  endtask

  task automatic check_lamp(input logic [1:0] road, input lamp_t expected, input string msg);
    check_value(32'(lamps[road]), 32'(expected), $sformatf("road %0d %s", road, msg));
  endtask

  // a level of n means the lowest n sensors of the road see a car.
  function automatic logic [SENSORS_PER_ROAD-1:0] sensor_pattern(input int level);
    case (level)
      0:       return 3'b000;
      1:       return 3'b001;
      2:       return 3'b011;
      default: return 3'b111;
    endcase
  endfunction

  function automatic bit all_red();
    for (int r = 0; r < NUM_ROADS; r++) begin
      if (lamps[r[1:0]] != LAMP_RED) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic int green_road();
    for (int r = 0; r < NUM_ROADS; r++) begin
      if (lamps[r[1:0]] == LAMP_GREEN) return r;
    end
    return -1;
  endfunction

  task automatic wait_lamp(input logic [1:0] road, input lamp_t colour, input string what);
    int cycles;
    cycles = 0;
    while (lamps[road] != colour) begin
      if (cycles == TIMEOUT) begin
        stop_with_failure($sformatf("timeout: the %s lamp never arrived on road %0d",
                                    what, road));
      end
      next_cycle();
      cycles++;
    end
  endtask

  task automatic wait_any_green(output logic [1:0] road);
    int cycles;
    cycles = 0;
    while (green_road() < 0) begin
      if (cycles == TIMEOUT) stop_with_failure("timeout: no road ever got a green lamp");
      next_cycle();
      cycles++;
    end
    road = 2'(green_road());
  endtask

  task automatic wait_all_red();
    int cycles;
    cycles = 0;
    while (!all_red()) begin
      if (cycles == TIMEOUT) stop_with_failure("timeout: the lamps never all returned to red");
      next_cycle();
      cycles++;
    end
  endtask

  task automatic idle_after_reset();
    for (int n = 0; n < 20; n++) begin
      check_value(32'(all_red()), 32'd1, "all lamps red with no demand");
      check_value(32'(camera), 32'd0, "camera low with no demand");
      next_cycle();
    end
  endtask

  task automatic busiest_road_wins();
    int         level [NUM_ROADS];
    int         best;
    int         expected_road;
    logic [1:0] green;
    best = 0;
    expected_road = 0;
    for (int r = 0; r < NUM_ROADS; r++) begin
      level[r] = int'($urandom % 4);
      if (level[r] > best) begin // ties stay with the lower road.
        best = level[r];
        expected_road = r;
      end
    end
    if (best == 0) begin
      level[2] = 1;
      expected_road = 2;
    end
    for (int r = 0; r < NUM_ROADS; r++) queue_sensors[r[1:0]] = sensor_pattern(level[r]);
    $display("queue levels %0d %0d %0d %0d", level[0], level[1], level[2], level[3]);
    wait_any_green(green);
    check_value(32'(green), 32'(expected_road), "first green goes to the busiest road");
    queue_sensors = '0;
    wait_all_red();
  endtask

  task automatic min_green_then_amber();
    int green_cycles;
    queue_sensors[1] = sensor_pattern(1);
    wait_lamp(2'd1, LAMP_GREEN, "green");
    queue_sensors[1] = sensor_pattern(0); // the queue clears at once.
    green_cycles = 0;
    while (lamps[1] == LAMP_GREEN) begin
      if (green_cycles == TIMEOUT) stop_with_failure("timeout: the green on road 1 never ended");
      check_value(32'(lamps[0] == LAMP_RED && lamps[2] == LAMP_RED && lamps[3] == LAMP_RED),
                  32'd1, "other roads red during the green");
      green_cycles++;
      next_cycle();
    end
    check_value(32'(green_cycles >= MIN_GREEN), 32'd1, "green lasts the minimum time");
    check_lamp(2'd1, LAMP_AMBER, "amber after the green");
    next_cycle();
    check_lamp(2'd1, LAMP_RED, "red after one amber cycle");
  endtask

  task automatic longer_queue_takes_over();
    logic [1:0] green;
    queue_sensors[1] = sensor_pattern(2);
    wait_lamp(2'd1, LAMP_GREEN, "green");
    repeat (MIN_GREEN + 1) begin
      check_lamp(2'd1, LAMP_GREEN, "holds green while queued");
      next_cycle();
    end
    check_lamp(2'd1, LAMP_GREEN, "still green in the extension");
    queue_sensors[2] = sensor_pattern(3);
    wait_lamp(2'd1, LAMP_AMBER, "amber");
    next_cycle();
    check_lamp(2'd1, LAMP_RED, "red after amber");
    wait_any_green(green);
    check_value(32'(green), 32'd2, "the longer queue gets the next green");
    queue_sensors = '0;
    wait_all_red();
  endtask

  task automatic siren_preemption();
    queue_sensors[0] = sensor_pattern(1);
    wait_lamp(2'd0, LAMP_GREEN, "green");
    siren[3] = 1'b1;
    repeat (2) next_cycle(); // one edge to amber phase, one more for the lamp.
    check_lamp(2'd0, LAMP_AMBER, "amber cuts the minimum green short");
    next_cycle();
    check_lamp(2'd0, LAMP_RED, "red after the cut green");
    queue_sensors[0] = sensor_pattern(0);
    wait_lamp(2'd3, LAMP_GREEN, "emergency green");
    repeat (10) begin
      check_lamp(2'd3, LAMP_GREEN, "green while the siren is held");
      check_lamp(2'd0, LAMP_RED, "red during the emergency");
      next_cycle();
    end
    siren[3] = 1'b0;
    wait_lamp(2'd3, LAMP_AMBER, "amber");
    next_cycle();
    check_lamp(2'd3, LAMP_RED, "red after the emergency amber");
  endtask

  task automatic camera_gating();
    wait_all_red();
    violation_cam[2] = 1'b1;
    next_cycle();
    check_value(32'(camera), 32'd1, "camera hit on a red road");
    violation_cam[2] = 1'b0;
    next_cycle();
    check_value(32'(camera), 32'd0, "camera drops with the hit");
    queue_sensors[1] = sensor_pattern(1);
    wait_lamp(2'd1, LAMP_GREEN, "green");
    queue_sensors[1] = sensor_pattern(0);
    violation_cam[1] = 1'b1;
    repeat (2) begin
      next_cycle();
      check_value(32'(camera), 32'd0, "no camera flag on the green road");
    end
    wait_all_red();
    check_value(32'(camera), 32'd1, "camera flags the same road once it leaves green");
    violation_cam[1] = 1'b0;
    next_cycle();
    check_value(32'(camera), 32'd0, "camera low after the hit ends");
  endtask

  initial begin
    void'($urandom(32'hdaab8696));
    reset         = 1'b1;
    queue_sensors = '0;
    siren         = '0;
    violation_cam = '0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    idle_after_reset();
    busiest_road_wins();
    min_green_then_amber();
    longer_queue_takes_over();
    siren_preemption();
    camera_gating();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== hw/traffic_junction.sv ====
`timescale 1ns/1ps

module traffic_junction import traffic_pkg::*; #(
  parameter int NUM_ROADS = 4,
  parameter int MIN_GREEN = 4
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic [NUM_ROADS-1:0][SENSORS_PER_ROAD-1:0]  queue_sensors,
  input  logic [NUM_ROADS-1:0]                        siren,
  input  logic [NUM_ROADS-1:0]                        violation_cam,
  output lamp_t [NUM_ROADS-1:0]                       lamps,
  output logic                                        camera
);

  localparam int ROAD_W = $clog2(NUM_ROADS);

  phase_t              phase;
  logic [ROAD_W-1:0]   active_road;
  logic [ROAD_W-1:0]   busiest_road;
  logic [ROAD_W-1:0]   siren_road;
  logic                any_demand;
  logic                any_siren;
  logic                longer_queue;
  queue_level_t        active_level;
  queue_level_t        queue_level [NUM_ROADS];
  logic [NUM_ROADS-1:0] cam_hit;

  phase_controller #(
    .NUM_ROADS (NUM_ROADS),
    .MIN_GREEN (MIN_GREEN)
  ) u_phase_controller (
    .clock        (clock),
    .reset        (reset),
    .any_demand   (any_demand),
    .busiest_road (busiest_road),
    .any_siren    (any_siren),
    .siren_road   (siren_road),
    .active_level (active_level),
    .longer_queue (longer_queue),
    .siren        (siren),
    .phase        (phase),
    .active_road  (active_road)
  );

  for (genvar i = 0; i < NUM_ROADS; i++) begin : g_road
    road_lane #(
      .NUM_ROADS  (NUM_ROADS),
      .ROAD_INDEX (i)
    ) u_road_lane (
      .clock       (clock),
      .reset       (reset),
      .phase       (phase),
      .active_road (active_road),
      .sensors     (queue_sensors[i]),
      .cam         (violation_cam[i]),
      .lamp        (lamps[i]),
      .queue_level (queue_level[i]),
      .cam_hit     (cam_hit[i])
    );
  end

  demand_arbiter #(
    .NUM_ROADS (NUM_ROADS)
  ) u_demand_arbiter (
    .clock        (clock),
    .reset        (reset),
    .queue_level  (queue_level),
    .siren        (siren),
    .cam_hit      (cam_hit),
    .active_road  (active_road),
    .busiest_road (busiest_road),
    .any_demand   (any_demand),
    .siren_road   (siren_road),
    .any_siren    (any_siren),
    .active_level (active_level),
    .longer_queue (longer_queue),
    .camera       (camera)
  );

endmodule

// ==== hw/phase_controller.sv ====
`timescale 1ns/1ps

module phase_controller import traffic_pkg::*; #(
  parameter int NUM_ROADS = 4,
  parameter int MIN_GREEN = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         any_demand,
  input  logic [$clog2(NUM_ROADS)-1:0] busiest_road,
  input  logic                         any_siren,
  input  logic [$clog2(NUM_ROADS)-1:0] siren_road,
  input  queue_level_t                 active_level,
  input  logic                         longer_queue,
  input  logic [NUM_ROADS-1:0]         siren,
  output phase_t                       phase,
  output logic [$clog2(NUM_ROADS)-1:0] active_road
);

  localparam int ROAD_W  = $clog2(NUM_ROADS);
  localparam int COUNT_W = $clog2(MIN_GREEN + 1);

  phase_t              phase_next;
  logic [ROAD_W-1:0]   road_next;
  logic [COUNT_W-1:0]  green_count;
  logic [COUNT_W-1:0]  count_next;
  logic                min_done;
  logic                hold_ext;

  assign min_done = (green_count == COUNT_W'(MIN_GREEN - 1));

  // the extension lasts while this road still queues and no one else queues longer.
  assign hold_ext = (active_level != '0) && !longer_queue && !any_siren;

  always_comb begin
    phase_next = phase;
    road_next  = active_road;
    count_next = '0;
    case (phase)
      PHASE_IDLE: begin
        if (any_siren) begin
          phase_next = PHASE_EMERGENCY;
          road_next  = siren_road;
        end else if (any_demand) begin
          phase_next = PHASE_PICK;
        end
      end

      PHASE_PICK: begin
        road_next  = busiest_road;
        phase_next = PHASE_MIN_GREEN;
      end

      PHASE_MIN_GREEN: begin
        if (any_siren) begin
          phase_next = PHASE_AMBER; // a siren cuts the minimum green short.
        end else if (min_done) begin
          phase_next = PHASE_EXT_GREEN;
        end else begin
          count_next = green_count + 1'b1;
        end
      end

      PHASE_EXT_GREEN: begin
        if (!hold_ext) phase_next = PHASE_AMBER;
      end

      PHASE_AMBER: begin
        phase_next = PHASE_IDLE; // amber is always a single cycle.
      end

      PHASE_EMERGENCY: begin
        if (!siren[active_road]) phase_next = PHASE_AMBER;
      end

      default: begin
        phase_next = PHASE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      phase       <= PHASE_IDLE;
      active_road <= '0;
      green_count <= '0;
    end else begin
      phase       <= phase_next;
      active_road <= road_next;
      green_count <= count_next;
    end
  end

endmodule

// ==== hw/demand_arbiter.sv ====
`timescale 1ns/1ps

module demand_arbiter import traffic_pkg::*; #(
  parameter int NUM_ROADS = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  queue_level_t                 queue_level [NUM_ROADS],
  input  logic [NUM_ROADS-1:0]         siren,
  input  logic [NUM_ROADS-1:0]         cam_hit,
  input  logic [$clog2(NUM_ROADS)-1:0] active_road,
  output logic [$clog2(NUM_ROADS)-1:0] busiest_road,
  output logic                         any_demand,
  output logic [$clog2(NUM_ROADS)-1:0] siren_road,
  output logic                         any_siren,
  output queue_level_t                 active_level,
  output logic                         longer_queue,
  output logic                         camera
);

  localparam int ROAD_W = $clog2(NUM_ROADS);

  queue_level_t best_level;

  // strict compare keeps the lowest index on a tie.
  always_comb begin
    busiest_road = '0;
    best_level   = queue_level[0];
    any_demand   = 1'b0;
    for (int i = 0; i < NUM_ROADS; i++) begin
      if (queue_level[i] > best_level) begin
        busiest_road = ROAD_W'(i);
        best_level   = queue_level[i];
      end
      if (queue_level[i] != '0) any_demand = 1'b1;
    end
  end

  // scanning downward leaves the lowest sirened road.
  always_comb begin
    siren_road = '0;
    for (int i = NUM_ROADS - 1; i >= 0; i--) begin
      if (siren[i]) siren_road = ROAD_W'(i);
    end
  end

  assign any_siren    = |siren;
  assign active_level = queue_level[active_road];

  always_comb begin
    longer_queue = 1'b0;
    for (int i = 0; i < NUM_ROADS; i++) begin
      if (ROAD_W'(i) != active_road && queue_level[i] > active_level) longer_queue = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) camera <= 1'b0;
    else       camera <= |cam_hit;
  end

endmodule

// ==== hw/road_lane.sv ====
`timescale 1ns/1ps

module road_lane import traffic_pkg::*; #(
  parameter int NUM_ROADS  = 4,
  parameter int ROAD_INDEX = 0
) (
  input  logic                         clock,
  input  logic                         reset,
  input  phase_t                       phase,
  input  logic [$clog2(NUM_ROADS)-1:0] active_road,
  input  logic [SENSORS_PER_ROAD-1:0]  sensors,
  input  logic                         cam,
  output lamp_t                        lamp,
  output queue_level_t                 queue_level,
  output logic                         cam_hit
);

  localparam int ROAD_W = $clog2(NUM_ROADS);

  logic is_active;

  assign is_active = (active_road == ROAD_W'(ROAD_INDEX));

  // the highest set sensor gives the level, so a gap in the sensor row is ignored.
  always_comb begin
    queue_level = '0;
    for (int i = 0; i < SENSORS_PER_ROAD; i++) begin
      if (sensors[i]) queue_level = queue_level_t'(i + 1);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      lamp <= LAMP_RED;
    end else if (is_active && (phase == PHASE_MIN_GREEN || phase == PHASE_EXT_GREEN ||
                               phase == PHASE_EMERGENCY)) begin
      lamp <= LAMP_GREEN;
    end else if (is_active && phase == PHASE_AMBER) begin
      lamp <= LAMP_AMBER;
    end else begin
      lamp <= LAMP_RED;
    end
  end

  assign cam_hit = cam && (lamp != LAMP_GREEN); // a car may pass a green lamp.

endmodule

// ==== hw/traffic_pkg.sv ====
package traffic_pkg;

  // one-hot lamp colour with red in the top bit and green in the bottom bit.
  typedef enum logic [2:0] {
    LAMP_RED   = 3'b100,
    LAMP_AMBER = 3'b010,
    LAMP_GREEN = 3'b001
  } lamp_t;

  typedef enum logic [2:0] {
    PHASE_IDLE      = 3'd0,
    PHASE_PICK      = 3'd1,
    PHASE_MIN_GREEN = 3'd2,
    PHASE_EXT_GREEN = 3'd3,
    PHASE_AMBER     = 3'd4,
    PHASE_EMERGENCY = 3'd5
  } phase_t;

  // number of queue sensors on one road, which is also the top queue level.
  localparam int SENSORS_PER_ROAD = 3;

  typedef logic [1:0] queue_level_t;

endpackage
